//--- source/cp0Package.sv
`default_nettype none

package cp0Package;

    typedef logic [31:0] cp0Word;     // Data and address word
    typedef logic [4:0]  regAddress;  // CP0 register number, select 0 only

    // Implemented CP0 registers
    localparam regAddress addrBadVAddr = 5'd8;
    localparam regAddress addrCount    = 5'd9;
    localparam regAddress addrCompare  = 5'd11;
    localparam regAddress addrStatus   = 5'd12;
    localparam regAddress addrCause    = 5'd13;
    localparam regAddress addrEpc      = 5'd14;

    // Cause ExcCode values, lower four bits
    typedef enum logic [3:0] {
        codeInterrupt   = 4'd0,
        codeAddrLoad    = 4'd4,   // AdEL, also instruction fetch
        codeAddrStore   = 4'd5,   // AdES
        codeSyscall     = 4'd8,
        codeBreak       = 4'd9,
        codeReserved    = 4'd10,  // Reserved instruction
        codeCopUnusable = 4'd11,
        codeOverflow    = 4'd12,
        codeTrap        = 4'd13
    } excCode;

    // One bit per pipeline stage: 3 MEM, 2 EX, 1 ID, 0 IF
    typedef logic [3:0] stageVector;

    // Status field positions
    localparam int statusBev   = 22;
    localparam int statusImLow = 8;   // IM occupies 15:8
    localparam int statusUm    = 4;
    localparam int statusExl   = 1;
    localparam int statusIe    = 0;

    // Cause field positions
    localparam int causeBd      = 31;
    localparam int causeIpLow   = 8;  // IP occupies 15:8
    localparam int causeCodeLow = 2;  // ExcCode occupies 5:2

    // General exception vector offset from the selected base
    localparam cp0Word generalOffset = 32'h0000_0180;

endpackage

`default_nettype wire

//--- source/timerInterrupt.sv
`timescale 1ns/1ps
`default_nettype none

module timerInterrupt import cp0Package::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       regWrite,           // Committed mtc0
    input  regAddress  regAddr,
    input  cp0Word     writeData,
    input  logic [4:0] hwInterrupt,        // External interrupt lines
    input  logic [7:0] interruptMask,      // Status IM
    input  logic       interruptEnable,    // Status IE
    input  logic       exceptionLevel,     // Status EXL
    input  logic       idIsFlushed,        // No real instruction in ID to attach to
    output cp0Word     countValue,
    output cp0Word     compareValue,
    output logic [7:0] pendingInterrupts,  // Cause IP
    output logic       interruptRequest
);

    logic countWrite;
    logic compareWrite;
    logic causeWrite;
    logic timerMatch;

    // This unit owns Count, Compare and the software half of Cause
    assign countWrite   = regWrite && (regAddr == addrCount);
    assign compareWrite = regWrite && (regAddr == addrCompare);
    assign causeWrite   = regWrite && (regAddr == addrCause);

    assign timerMatch = (countValue == compareValue);

    always_ff @(posedge clock) begin
        if (reset) begin
            countValue   <= '0;
            compareValue <= '0;
        end else begin
            countValue <= countWrite ? writeData : countValue + 32'd1;  // Free running
            if (compareWrite) begin
                compareValue <= writeData;
            end
        end
    end

    // Pending bits: 7 timer, 6..2 hardware, 1..0 software
    always_ff @(posedge clock) begin
        if (reset) begin
            pendingInterrupts <= '0;
        end else begin
            if (compareWrite) begin
                pendingInterrupts[7] <= 1'b0;  // Writing Compare acknowledges the timer
            end else if (timerMatch) begin
                pendingInterrupts[7] <= 1'b1;
            end
            pendingInterrupts[6:2] <= hwInterrupt;  // Level sensitive, one cycle late
            if (causeWrite) begin
                pendingInterrupts[1:0] <= writeData[causeIpLow +: 2];
            end
        end
    end

    // Any unmasked pending bit while interrupts are on and not already handling one
    assign interruptRequest = interruptEnable && ((pendingInterrupts & interruptMask) != 8'h00)
                              && !exceptionLevel && !idIsFlushed;

endmodule

`default_nettype wire

//--- source/exceptionArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module exceptionArbiter import cp0Package::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       mtc0,
    input  logic       mfc0,
    input  logic       eret,
    input  logic       ifStall,
    input  logic       idStall,           // Nothing commits while ID is held
    input  logic       kernelMode,
    input  logic       interruptRequest,  // Enabled interrupt from the timer unit
    input  logic       excAdIf,           // Fetch address error
    input  logic       excAdEl,           // Load address error
    input  logic       excAdEs,           // Store address error
    input  logic       excOv,
    input  logic       excTr,
    input  logic       excSys,
    input  logic       excBp,
    input  logic       excRi,
    input  logic       idCanErr,          // Cumulative from ID forward
    input  logic       exCanErr,          // Cumulative from EX forward
    input  logic       memCanErr,
    output logic       regWrite,
    output logic       eretCommit,
    output stageVector stageStall,
    output stageVector stageFlush,
    output stageVector stageReady,        // At most one bit
    output excCode     raisedCode
);

    logic       copUnusable;
    logic       interruptTaken;
    logic       resetDelayed;
    stageVector detect;         // Exception present in each stage
    stageVector mask;           // Stage must wait on something
    stageVector forwardDetect;  // Some later stage has an exception
    stageVector stallCause;

    // CP0 instructions are privileged
    assign copUnusable = (mtc0 || mfc0 || eret) && !kernelMode;

    // Interrupts are inserted in ID
    assign interruptTaken = interruptRequest;

    assign detect[3] = excAdEl || excAdEs || excTr;
    assign detect[2] = excOv;
    assign detect[1] = excSys || excBp || excRi || copUnusable || interruptTaken;
    assign detect[0] = excAdIf;

    assign forwardDetect = {1'b0, detect[3], |detect[3:2], |detect[3:1]};

    // A stage waits while a later stage may still fault
    assign mask[3] = ifStall;
    assign mask[2] = ifStall || memCanErr;
    assign mask[1] = ifStall || memCanErr || exCanErr;
    assign mask[0] = memCanErr || exCanErr || idCanErr || interruptTaken;

    // CP0 writes and ERET also wait for the stages ahead to clear
    assign stallCause = {detect[3:2], detect[1] || eret || mtc0, detect[0]};

    assign stageStall = stallCause & mask & ~forwardDetect;

    // Oldest unmasked exception only
    assign stageReady = {4{!idStall}} & detect & ~mask & ~forwardDetect;

    assign regWrite   = mtc0 && kernelMode && !idStall;
    assign eretCommit = eret && !idStall;

    always_ff @(posedge clock) begin
        resetDelayed <= reset;  // IF refetches from the reset vector
    end

    // A faulting stage squashes itself and everything younger
    assign stageFlush = detect | forwardDetect | {3'b000, eretCommit || resetDelayed};

    // MEM first, then EX, ID, IF, interrupts last
    always_comb begin
        if (excAdEl) begin
            raisedCode = codeAddrLoad;
        end else if (excAdEs) begin
            raisedCode = codeAddrStore;
        end else if (excTr) begin
            raisedCode = codeTrap;
        end else if (excOv) begin
            raisedCode = codeOverflow;
        end else if (excSys) begin
            raisedCode = codeSyscall;
        end else if (excBp) begin
            raisedCode = codeBreak;
        end else if (excRi) begin
            raisedCode = codeReserved;
        end else if (copUnusable) begin
            raisedCode = codeCopUnusable;
        end else if (excAdIf) begin
            raisedCode = codeAddrLoad;   // Fetch errors report as AdEL
        end else begin
            raisedCode = codeInterrupt;
        end
    end

endmodule

`default_nettype wire

//--- source/exceptionState.sv
`timescale 1ns/1ps
`default_nettype none

module exceptionState import cp0Package::*; #(
    parameter cp0Word resetVector = 32'hBFC0_0000,
    parameter cp0Word bootBase    = 32'hBFC0_0200,  // Exception base while BEV is set
    parameter cp0Word normalBase  = 32'h8000_0000
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       regWrite,
    input  logic       eretCommit,
    input  logic       mfc0,
    input  regAddress  regAddr,
    input  cp0Word     writeData,
    input  stageVector stageReady,
    input  excCode     raisedCode,
    input  cp0Word     idRestartPc,     // Branch PC when in a delay slot
    input  cp0Word     exRestartPc,
    input  cp0Word     memRestartPc,
    input  logic       ifIsDelaySlot,
    input  logic       idIsDelaySlot,
    input  logic       exIsDelaySlot,
    input  logic       memIsDelaySlot,
    input  cp0Word     memBadAddr,      // Faulting data address
    input  cp0Word     ifBadAddr,       // Faulting fetch address
    input  cp0Word     countValue,
    input  cp0Word     compareValue,
    input  logic [7:0] pendingInterrupts,
    output cp0Word     readData,
    output logic       kernelMode,
    output logic [7:0] interruptMask,   // Status IM
    output logic       interruptEnable, // Status IE
    output logic       exceptionLevel,  // Status EXL
    output logic       excPcSel,
    output cp0Word     excPcOut
);

    logic   bootVectors;   // Status BEV
    logic   userMode;      // Status UM
    cp0Word exceptionPc;   // EPC
    cp0Word badVAddr;
    logic   branchDelay;   // Cause BD
    excCode causeCode;
    logic   statusWrite;
    logic   epcWrite;
    logic   exceptionTaken;
    cp0Word readyPc;
    logic   readyDelaySlot;
    cp0Word statusWord;
    cp0Word causeWord;

    // Status and EPC belong here; the timer unit decodes the rest
    assign statusWrite = regWrite && (regAddr == addrStatus);
    assign epcWrite    = regWrite && (regAddr == addrEpc);

    assign exceptionTaken = (stageReady != 4'b0000);

    // Restart point of the stage being taken
    always_comb begin
        readyPc        = ifBadAddr;  // IF restarts at the bad fetch address
        readyDelaySlot = ifIsDelaySlot;
        if (stageReady[3]) begin
            readyPc        = memRestartPc;
            readyDelaySlot = memIsDelaySlot;
        end else if (stageReady[2]) begin
            readyPc        = exRestartPc;
            readyDelaySlot = exIsDelaySlot;
        end else if (stageReady[1]) begin
            readyPc        = idRestartPc;
            readyDelaySlot = idIsDelaySlot;
        end
    end

    // Software fields of Status
    always_ff @(posedge clock) begin
        if (reset) begin
            bootVectors     <= 1'b1;  // Boot vectors until software switches
            interruptMask   <= '0;
            userMode        <= 1'b0;
            interruptEnable <= 1'b0;
        end else if (statusWrite) begin
            bootVectors     <= writeData[statusBev];
            interruptMask   <= writeData[statusImLow +: 8];
            userMode        <= writeData[statusUm];
            interruptEnable <= writeData[statusIe];
        end
    end

    // Exception capture, EXL, EPC and BadVAddr
    always_ff @(posedge clock) begin
        if (reset) begin
            exceptionLevel <= 1'b0;
            exceptionPc    <= '0;
            badVAddr       <= '0;
            branchDelay    <= 1'b0;
            causeCode      <= codeInterrupt;
        end else if (exceptionTaken) begin
            causeCode      <= raisedCode;
            exceptionLevel <= 1'b1;
            if (!exceptionLevel) begin
                // Nested exception keeps the original return point
                exceptionPc <= readyPc;
                branchDelay <= readyDelaySlot;
            end
            if (stageReady[3]) begin
                badVAddr <= memBadAddr;
            end else if (stageReady[0]) begin
                badVAddr <= ifBadAddr;
            end
        end else begin
            if (statusWrite) begin
                exceptionLevel <= writeData[statusExl];
            end else if (eretCommit) begin
                exceptionLevel <= 1'b0;  // Back to the interrupted mode
            end
            if (epcWrite) begin
                exceptionPc <= writeData;
            end
        end
    end

    assign kernelMode = !userMode || exceptionLevel;

    always_comb begin
        statusWord                      = '0;
        statusWord[statusBev]           = bootVectors;
        statusWord[statusImLow +: 8]    = interruptMask;
        statusWord[statusUm]            = userMode;
        statusWord[statusExl]           = exceptionLevel;
        statusWord[statusIe]            = interruptEnable;
        causeWord                       = '0;
        causeWord[causeBd]              = branchDelay;
        causeWord[causeIpLow +: 8]      = pendingInterrupts;
        causeWord[causeCodeLow +: 4]    = causeCode;
    end

    // mfc0 read port, zero outside kernel mode
    always_comb begin
        readData = '0;
        if (mfc0 && kernelMode) begin
            case (regAddr)
                addrBadVAddr: readData = badVAddr;
                addrCount:    readData = countValue;
                addrCompare:  readData = compareValue;
                addrStatus:   readData = statusWord;
                addrCause:    readData = causeWord;
                addrEpc:      readData = exceptionPc;
                default:      readData = '0;
            endcase
        end
    end

    assign excPcSel = reset || eretCommit || exceptionTaken;

    always_comb begin
        if (reset) begin
            excPcOut = resetVector;
        end else if (eretCommit) begin
            excPcOut = exceptionPc;
        end else begin
            excPcOut = (bootVectors ? bootBase : normalBase) + generalOffset;
        end
    end

endmodule

`default_nettype wire

//--- source/coprocessorZero.sv
`timescale 1ns/1ps
`default_nettype none

module coprocessorZero import cp0Package::*; #(
    parameter cp0Word resetVector = 32'hBFC0_0000,
    parameter cp0Word bootBase    = 32'hBFC0_0200,
    parameter cp0Word normalBase  = 32'h8000_0000
) (
    input  logic       clock,
    input  logic       reset,
    input  logic [4:0] hwInterrupt,
    input  logic       excAdIf,
    input  logic       excAdEl,
    input  logic       excAdEs,
    input  logic       excOv,
    input  logic       excTr,
    input  logic       excSys,
    input  logic       excBp,
    input  logic       excRi,
    input  logic       mtc0,
    input  logic       mfc0,
    input  logic       eret,
    input  logic       ifStall,
    input  logic       idStall,
    input  logic       idCanErr,
    input  logic       exCanErr,
    input  logic       memCanErr,
    input  regAddress  regAddr,          // rd field of mtc0 / mfc0
    input  cp0Word     writeData,        // GPR value for mtc0
    input  cp0Word     idRestartPc,
    input  cp0Word     exRestartPc,
    input  cp0Word     memRestartPc,
    input  cp0Word     memBadAddr,
    input  cp0Word     ifBadAddr,
    input  logic       ifIsDelaySlot,
    input  logic       idIsDelaySlot,
    input  logic       exIsDelaySlot,
    input  logic       memIsDelaySlot,
    input  logic       idIsFlushed,
    output cp0Word     readData,         // mfc0 result
    output logic       kernelMode,
    output logic [7:0] pendingInterrupts,
    output stageVector exceptionStall,   // MEM EX ID IF
    output stageVector exceptionFlush,
    output logic       excPcSel,
    output cp0Word     excPcOut
);

    logic       regWrite;
    logic       eretCommit;
    stageVector stageReady;
    excCode     raisedCode;
    cp0Word     countValue;
    cp0Word     compareValue;
    logic [7:0] interruptMask;
    logic       interruptEnable;
    logic       exceptionLevel;
    logic       interruptRequest;

    timerInterrupt timer (
        .clock, .reset, .regWrite, .regAddr, .writeData, .hwInterrupt,
        .interruptMask, .interruptEnable, .exceptionLevel, .idIsFlushed,
        .countValue, .compareValue, .pendingInterrupts, .interruptRequest
    );

    exceptionArbiter arbiter (
        .clock, .reset, .mtc0, .mfc0, .eret, .ifStall, .idStall, .kernelMode,
        .interruptRequest, .excAdIf, .excAdEl, .excAdEs, .excOv, .excTr, .excSys,
        .excBp, .excRi, .idCanErr, .exCanErr, .memCanErr, .regWrite, .eretCommit,
        .stageStall (exceptionStall),
        .stageFlush (exceptionFlush),
        .stageReady, .raisedCode
    );

    exceptionState #(
        .resetVector (resetVector),
        .bootBase    (bootBase),
        .normalBase  (normalBase)
    ) state (
        .clock, .reset, .regWrite, .eretCommit, .mfc0, .regAddr, .writeData,
        .stageReady, .raisedCode, .idRestartPc, .exRestartPc, .memRestartPc,
        .ifIsDelaySlot, .idIsDelaySlot, .exIsDelaySlot, .memIsDelaySlot,
        .memBadAddr, .ifBadAddr, .countValue, .compareValue, .pendingInterrupts,
        .readData, .kernelMode, .interruptMask, .interruptEnable, .exceptionLevel,
        .excPcSel, .excPcOut
    );

endmodule

`default_nettype wire

//--- bench/coprocessorZero_props.sv
`timescale 1ns/1ps
`default_nettype none

module coprocessorZeroProps import cp0Package::*; (
    input logic       clock,
    input logic       reset,
    input stageVector stageReady,
    input stageVector stageFlush
);

    int readyFailures = 0;
    int flushFailures = 0;

    // Only the oldest faulting stage may commit its exception
    readyOneHot: assert property (@(posedge clock) disable iff (reset) $onehot0(stageReady))
        else begin
            readyFailures++;
            $error("stageReady has more than one stage set: %b", stageReady);
        end

    // A flushed stage takes every younger stage with it
    flushOrder: assert property (@(posedge clock) disable iff (reset)
            stageFlush inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
        else begin
            flushFailures++;
            $error("stageFlush skips a younger stage: %b", stageFlush);
        end

endmodule

bind exceptionArbiter coprocessorZeroProps props (.clock, .reset, .stageReady, .stageFlush);

`default_nettype wire

//--- bench/coprocessorZeroChecker.sv
`timescale 1ns/1ps
`default_nettype none

module coprocessorZeroChecker import cp0Package::*; (
    input  logic       clock,
    input  logic       checkEnable,       // High while a golden line is applied
    input  cp0Word     readData,
    input  logic       kernelMode,
    input  logic [7:0] pendingInterrupts,
    input  stageVector exceptionStall,
    input  stageVector exceptionFlush,
    input  logic       excPcSel,
    input  cp0Word     excPcOut,
    input  cp0Word     expReadData,
    input  logic       expKernelMode,
    input  logic [7:0] expPending,
    input  stageVector expStall,
    input  stageVector expFlush,
    input  logic       expPcSel,
    input  cp0Word     expPcOut,
    output int         errorCount,
    output int         checkCount
);

    localparam int sampleDelay = 18;  // 2 ns ahead of the next edge

    task automatic compareField(input string name, input cp0Word actual, input cp0Word expected);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        forever begin
            @(posedge clock);
            #sampleDelay;
            if (checkEnable) begin
                checkCount++;
                compareField("readData", readData, expReadData);
                compareField("kernelMode", 32'(kernelMode), 32'(expKernelMode));
                compareField("pendingInterrupts", 32'(pendingInterrupts), 32'(expPending));
                // Stage vectors read MEM EX ID IF
                compareField("exceptionStall", 32'(exceptionStall), 32'(expStall));
                compareField("exceptionFlush", 32'(exceptionFlush), 32'(expFlush));
                compareField("excPcSel", 32'(excPcSel), 32'(expPcSel));
                compareField("excPcOut", excPcOut, expPcOut);
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/coprocessorZeroBench.sv
`timescale 1ns/1ps
`default_nettype none

module coprocessorZeroBench import cp0Package::*; ();

    localparam int clockPeriod = 20;
    localparam int fieldCount  = 14;   // Hex words per golden line
    localparam int maxLines    = 128;

    logic       clock;
    logic       reset;
    logic [4:0] hwInterrupt;
    logic       excAdIf, excAdEl, excAdEs, excOv, excTr, excSys, excBp, excRi;
    logic       mtc0, mfc0, eret;
    logic       ifStall, idStall;
    logic       idCanErr, exCanErr, memCanErr;
    regAddress  regAddr;
    cp0Word     writeData;
    cp0Word     idRestartPc, exRestartPc, memRestartPc;
    cp0Word     memBadAddr, ifBadAddr;
    logic       ifIsDelaySlot, idIsDelaySlot, exIsDelaySlot, memIsDelaySlot;
    logic       idIsFlushed;
    cp0Word     readData;
    logic       kernelMode;
    logic [7:0] pendingInterrupts;
    stageVector exceptionStall;
    stageVector exceptionFlush;
    logic       excPcSel;
    cp0Word     excPcOut;

    // Expected values of the current golden line
    logic       checkEnable;
    cp0Word     expReadData;
    logic       expKernelMode;
    logic [7:0] expPending;
    stageVector expStall;
    stageVector expFlush;
    logic       expPcSel;
    cp0Word     expPcOut;
    int         errorCount;
    int         checkCount;
    int         assertFailures;
    int         lineCount;

    logic [31:0] golden [0:fieldCount*maxLines-1];

    coprocessorZero UUT (.*);

    coprocessorZeroChecker outputCheck (.*);

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // All pipeline controls idle
    task automatic clearControls();
        {mtc0, mfc0, eret, ifStall, idStall} = '0;
        {excAdIf, excAdEl, excAdEs, excOv, excTr, excSys, excBp, excRi} = '0;
        {idCanErr, exCanErr, memCanErr} = '0;
        hwInterrupt = '0;
        regAddr     = '0;
        writeData   = '0;
    endtask

    // All-ones marks words past the end of the file
    task automatic loadGolden();
        for (int i = 0; i < fieldCount * maxLines; i++) begin
            golden[i] = '1;
        end
        $readmemh("bench/cp0_golden.txt", golden);
        lineCount = 0;
        while (lineCount < maxLines && golden[lineCount * fieldCount] != 32'hFFFF_FFFF) begin
            lineCount++;
        end
    endtask

    task automatic applyLine(input int line);
        int base;
        base = line * fieldCount;
        {mtc0, mfc0, eret} = golden[base][2:0];
        {ifStall, idStall} = golden[base + 1][1:0];
        {excAdIf, excAdEl, excAdEs, excOv, excTr, excSys, excBp, excRi} = golden[base + 2][7:0];
        {idCanErr, exCanErr, memCanErr} = golden[base + 3][2:0];
        hwInterrupt   = golden[base + 4][4:0];
        regAddr       = golden[base + 5][4:0];
        writeData     = golden[base + 6];
        expReadData   = golden[base + 7];
        expKernelMode = golden[base + 8][0];
        expPending    = golden[base + 9][7:0];
        expStall      = golden[base + 10][3:0];
        expFlush      = golden[base + 11][3:0];
        expPcSel      = golden[base + 12][0];
        expPcOut      = golden[base + 13];
    endtask

    initial begin
        reset        = 1'b1;
        checkEnable  = 1'b0;
        idRestartPc  = 32'h0040_0104;
        exRestartPc  = 32'h0040_0108;
        memRestartPc = 32'h0040_010C;
        memBadAddr   = 32'h1000_0003;  // Misaligned data access
        ifBadAddr    = 32'h0040_0201;
        {ifIsDelaySlot, idIsDelaySlot, exIsDelaySlot, memIsDelaySlot} = '0;
        idIsFlushed  = 1'b0;
        {expReadData, expKernelMode, expPending, expStall, expFlush} = '0;
        {expPcSel, expPcOut} = '0;
        clearControls();
        loadGolden();
        repeat (2) @(posedge clock);
        #2;
        reset       = 1'b0;
        checkEnable = 1'b1;
        for (int line = 0; line < lineCount; line++) begin
            applyLine(line);  // Settles 2 ns after the edge
            @(posedge clock);
            #2;
        end
        checkEnable = 1'b0;
        clearControls();
        assertFailures = UUT.arbiter.props.readyFailures + UUT.arbiter.props.flushFailures;
        $display("Checked %0d of %0d lines: %0d value errors, %0d assertion failures",
                 checkCount, lineCount, errorCount, assertFailures);
        if (errorCount == 0 && assertFailures == 0 && lineCount > 0 && checkCount == lineCount) begin
            $display("Done: no errors");
        end else begin
            if (lineCount == 0) begin
                $display("No stimulus lines could be read from the golden file");
            end
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the golden length, reset and a margin
    initial begin
        #1;
        #((lineCount + 12) * clockPeriod);
        $display("Timeout: the golden sequence did not complete in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/cp0_golden.txt
// op{mtc0,mfc0,eret} stall{if,id} exc{AdIf,AdEl,AdEs,Ov,Tr,Sys,Bp,Ri} canErr{id,ex,mem} hw addr wdata
// expected: readData kernel pending stall flush pcSel pcOut (stage vectors MEM EX ID IF)
4 0 00 0 00 0b 00000100  00000000 1 00 0 1 0 bfc00380
2 0 00 0 00 0b 00000000  00000100 1 00 0 0 0 bfc00380
4 0 00 0 00 0c 1050fc00  00000000 1 00 0 0 0 bfc00380
2 0 00 0 00 0c 00000000  0040fc00 1 00 0 0 0 bfc00380
4 0 00 0 00 0e 12345678  00000000 1 00 0 0 0 bfc00380
2 0 00 0 00 0e 00000000  12345678 1 00 0 0 0 bfc00380
4 0 00 0 00 09 00000040  00000000 1 00 0 0 0 bfc00380
2 0 00 0 00 09 00000000  00000040 1 00 0 0 0 bfc00380
2 0 00 0 00 09 00000000  00000041 1 00 0 0 0 bfc00380
4 0 00 0 00 0b 00000044  00000000 1 00 0 0 0 bfc00380
0 0 00 0 00 00 00000000  00000000 1 00 0 0 0 bfc00380
0 0 00 0 00 00 00000000  00000000 1 00 0 0 0 bfc00380
2 0 00 0 00 0d 00000000  00008000 1 80 0 0 0 bfc00380
4 0 00 0 00 0b 00000100  00000000 1 80 0 0 0 bfc00380
0 0 00 0 00 00 00000000  00000000 1 00 0 0 0 bfc00380
4 0 00 0 00 0c 0000fc00  00000000 1 00 0 0 0 bfc00380
0 0 0c 0 00 00 00000000  00000000 1 00 0 f 1 80000180
2 0 00 0 00 0e 00000000  0040010c 1 00 0 0 0 80000180
2 0 00 0 00 0d 00000000  00000034 1 00 0 0 0 80000180
2 0 00 0 00 0c 00000000  0000fc02 1 00 0 0 0 80000180
2 0 00 0 00 08 00000000  10000003 1 00 0 0 0 80000180
1 0 00 0 00 00 00000000  00000000 1 00 0 1 1 0040010c
2 0 00 0 00 0c 00000000  0000fc00 1 00 0 0 0 80000180
0 0 10 1 00 00 00000000  00000000 1 00 4 7 0 80000180
0 0 10 0 00 00 00000000  00000000 1 00 0 7 1 80000180
2 0 00 0 00 0e 00000000  00400108 1 00 0 0 0 80000180
1 0 00 0 00 00 00000000  00000000 1 00 0 1 1 00400108
4 0 00 0 00 0c 00007801  00000000 1 00 0 0 0 80000180
0 0 00 0 01 00 00000000  00000000 1 00 0 0 0 80000180
0 0 00 0 01 00 00000000  00000000 1 04 0 0 0 80000180
4 0 00 0 01 0c 00000401  00000000 1 04 0 0 0 80000180
0 0 00 0 01 00 00000000  00000000 1 04 0 3 1 80000180
2 0 00 0 00 0d 00000000  00000400 1 04 0 0 0 80000180
2 0 00 0 00 0e 00000000  00400104 1 00 0 0 0 80000180
1 0 00 0 00 00 00000000  00000000 1 00 0 1 1 00400104
2 0 00 0 00 0c 00000000  00000401 1 00 0 0 0 80000180
4 0 00 0 00 0c 00000010  00000000 1 00 0 0 0 80000180
2 0 00 0 00 0c 00000000  00000000 0 00 0 3 1 80000180
2 0 00 0 00 0d 00000000  0000002c 1 00 0 0 0 80000180
2 0 00 0 00 0c 00000000  00000012 1 00 0 0 0 80000180
2 0 00 0 00 0e 00000000  00400104 1 00 0 0 0 80000180

//--- build.f
source/cp0Package.sv
source/timerInterrupt.sv
source/exceptionArbiter.sv
source/exceptionState.sv
source/coprocessorZero.sv
bench/coprocessorZero_props.sv
bench/coprocessorZeroChecker.sv
bench/coprocessorZeroBench.sv

//--- Makefile
# Verilator build and run of the CP0 testbench
TOP = coprocessorZeroBench

all: run

obj_dir/V$(TOP): build.f $(wildcard source/*.sv bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps --top-module coprocessorZero \
		source/cp0Package.sv source/timerInterrupt.sv source/exceptionArbiter.sv \
		source/exceptionState.sv source/coprocessorZero.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
